// ==== src/eth_tx_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the byte-wide tx framer
// min_frame_len counts bytes including the FCS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package eth_tx_pkg;

    // reflected form of 04C11DB7
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam int FCS_BYTES = 4;
    localparam logic [7:0] DEFAULT_MIN_FRAME_LEN = 8'd64;

    // register map
    localparam logic [1:0] CSR_ADDR_CTRL = 2'd0;
    localparam logic [1:0] CSR_ADDR_MINLEN = 2'd1;
    localparam logic [1:0] CSR_ADDR_FRAMES = 2'd2;
    localparam logic [1:0] CSR_ADDR_ERRORS = 2'd3;

    // one stream transfer, user is the bad-frame flag on last
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } stream_beat_t;

    typedef struct packed {
        logic        write;
        logic [1:0]  addr;
        logic [15:0] wdata;
    } cfg_cmd_t;

    typedef struct packed {
        logic       pad_enable;
        logic [7:0] min_frame_len;
    } tx_cfg_t;

    // single-cycle pulses
    typedef struct packed {
        logic frame_done;
        logic frame_bad;
    } tx_event_t;

endpackage

// ==== src/eth_crc32_byte.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one byte of reflected CRC-32, LSB first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_crc32_byte (
    input  logic [7:0]  data,
    input  logic [31:0] crc_in,
    output logic [31:0] crc_out
);

    always_comb begin
        logic [31:0] c;

        // fold the byte into the low end first
        c = crc_in ^ {24'h0, data};

        // one shift per data bit
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ eth_tx_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end

        crc_out = c;
    end

endmodule

// ==== src/eth_fcs_insert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// config is sampled on the first beat of a frame
// pad length count wraps for frames over 64k bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_fcs_insert (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_pkg::tx_cfg_t      cfg,
    input  eth_tx_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    output eth_tx_pkg::stream_beat_t o_beat,
    output logic                     o_valid,
    input  logic                     o_ready,
    output eth_tx_pkg::tx_event_t    events,
    output logic                     busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS
    } state_t;

    state_t state_q, state_d;

    logic [15:0] cnt_q, cnt_d;
    logic [31:0] crc_q, crc_next;
    logic        crc_update, crc_clear;

    eth_tx_pkg::tx_cfg_t cfg_q, cfg_cur;
    logic [15:0]         pad_target;

    eth_crc32_byte crc_inst (
        .data    (o_beat.data),
        .crc_in  (crc_q),
        .crc_out (crc_next)
    );

    // first beat of a frame sees the live config
    assign cfg_cur = (state_q == ST_IDLE) ? cfg : cfg_q;

    // payload plus pad target, zero means no pad
    always_comb begin
        if (cfg_cur.min_frame_len > eth_tx_pkg::FCS_BYTES) begin
            pad_target = {8'h0, cfg_cur.min_frame_len} - 16'(eth_tx_pkg::FCS_BYTES);
        end else begin
            pad_target = '0;
        end
    end

    assign busy = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        cnt_d = cnt_q;
        crc_update = 1'b0;
        crc_clear = 1'b0;
        s_ready = 1'b0;
        o_valid = 1'b0;
        o_beat = '0;
        events = '0;

        case (state_q)
            ST_IDLE, ST_PAYLOAD: begin
                // straight pass-through of client bytes
                s_ready = o_ready;
                o_valid = s_valid;
                o_beat.data = s_beat.data;
                o_beat.last = s_beat.last & s_beat.user;
                o_beat.user = s_beat.last & s_beat.user;

                if (s_valid && o_ready) begin
                    cnt_d = cnt_q + 16'd1;
                    crc_update = 1'b1;
                    state_d = ST_PAYLOAD;
                    if (s_beat.last) begin
                        if (s_beat.user) begin
                            // bad frame ends here, nothing appended
                            crc_clear = 1'b1;
                            cnt_d = '0;
                            state_d = ST_IDLE;
                            events.frame_bad = 1'b1;
                        end else if (cfg_cur.pad_enable && (cnt_q + 16'd1 < pad_target)) begin
                            state_d = ST_PAD;
                        end else begin
                            cnt_d = '0;
                            state_d = ST_FCS;
                        end
                    end
                end
            end
            ST_PAD: begin
                o_valid = 1'b1;
                if (o_ready) begin
                    cnt_d = cnt_q + 16'd1;
                    crc_update = 1'b1;
                    if (cnt_q + 16'd1 >= pad_target) begin
                        cnt_d = '0;
                        state_d = ST_FCS;
                    end
                end
            end
            ST_FCS: begin
                // complemented crc, low byte first
                o_valid = 1'b1;
                o_beat.data = ~crc_q[8*cnt_q[1:0] +: 8];
                o_beat.last = (cnt_q[1:0] == 2'd3);
                if (o_ready) begin
                    cnt_d = cnt_q + 16'd1;
                    if (cnt_q[1:0] == 2'd3) begin
                        crc_clear = 1'b1;
                        cnt_d = '0;
                        state_d = ST_IDLE;
                        events.frame_done = 1'b1;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
            crc_q <= eth_tx_pkg::CRC_INIT;
            cfg_q <= '0;
        end else begin
            state_q <= state_d;
            cnt_q <= cnt_d;
            if (crc_clear) begin
                crc_q <= eth_tx_pkg::CRC_INIT;
            end else if (crc_update) begin
                crc_q <= crc_next;
            end
            if (state_q == ST_IDLE && s_valid && o_ready) begin
                cfg_q <= cfg;
            end
        end
    end

endmodule

// ==== src/axis_skid_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered valid, data and ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module axis_skid_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    output eth_tx_pkg::stream_beat_t m_beat,
    output logic                     m_valid,
    input  logic                     m_ready
);

    eth_tx_pkg::stream_beat_t main_q, spare_q;
    logic main_valid, spare_valid;
    logic ready_q, ready_early;
    logic load_main, load_spare, spare_to_main;

    assign s_ready = ready_q;
    assign m_beat = main_q;
    assign m_valid = main_valid;

    // stay ready unless the spare entry could fill next cycle
    assign ready_early = m_ready || (!spare_valid && (!main_valid || !s_valid));

    always_comb begin
        load_main = ready_q && (m_ready || !main_valid);
        load_spare = ready_q && !m_ready && main_valid;
        spare_to_main = !ready_q && m_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            spare_valid <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            if (load_main) begin
                main_valid <= s_valid;
            end else if (spare_to_main) begin
                main_valid <= spare_valid;
                spare_valid <= 1'b0;
            end
            if (load_spare) begin
                spare_valid <= s_valid;
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load_main) begin
            main_q <= s_beat;
        end else if (spare_to_main) begin
            main_q <= spare_q;
        end
        if (load_spare) begin
            spare_q <= s_beat;
        end
    end

endmodule

// ==== src/eth_tx_csr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase port, one access per request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_tx_csr (
    input  logic                  clk,
    input  logic                  rst,
    input  eth_tx_pkg::cfg_cmd_t  cfg_cmd,
    input  logic                  cfg_req,
    output logic                  cfg_ack,
    output logic [15:0]           cfg_rdata,
    input  eth_tx_pkg::tx_event_t events,
    output eth_tx_pkg::tx_cfg_t   cfg
);

    logic        ack_q;
    logic        pad_enable_q;
    logic [7:0]  min_len_q;
    logic [15:0] frames_q, errors_q;
    logic [15:0] rdata_q, rd_mux;
    logic        access;

    assign cfg_ack = ack_q;
    assign cfg_rdata = rdata_q;
    assign cfg.pad_enable = pad_enable_q;
    assign cfg.min_frame_len = min_len_q;

    // rising edge of the request, ack not yet given
    assign access = cfg_req && !ack_q;

    always_comb begin
        case (cfg_cmd.addr)
            eth_tx_pkg::CSR_ADDR_CTRL: rd_mux = {15'h0, pad_enable_q};
            eth_tx_pkg::CSR_ADDR_MINLEN: rd_mux = {8'h0, min_len_q};
            eth_tx_pkg::CSR_ADDR_FRAMES: rd_mux = frames_q;
            default: rd_mux = errors_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            pad_enable_q <= 1'b0;
            min_len_q <= eth_tx_pkg::DEFAULT_MIN_FRAME_LEN;
            frames_q <= '0;
            errors_q <= '0;
        end else begin
            ack_q <= cfg_req;
            if (access && cfg_cmd.write) begin
                if (cfg_cmd.addr == eth_tx_pkg::CSR_ADDR_CTRL) begin
                    pad_enable_q <= cfg_cmd.wdata[0];
                end
                if (cfg_cmd.addr == eth_tx_pkg::CSR_ADDR_MINLEN) begin
                    min_len_q <= cfg_cmd.wdata[7:0];
                end
            end
            // counters wrap at 16 bits
            frames_q <= frames_q + 16'(events.frame_done);
            errors_q <= errors_q + 16'(events.frame_bad);
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rd_mux;
        end
    end

endmodule

// ==== src/eth_tx_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framer top, payload in and framed bytes out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_tx_top (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    output eth_tx_pkg::stream_beat_t m_beat,
    output logic                     m_valid,
    input  logic                     m_ready,
    input  eth_tx_pkg::cfg_cmd_t     cfg_cmd,
    input  logic                     cfg_req,
    output logic                     cfg_ack,
    output logic [15:0]              cfg_rdata,
    output logic                     busy
);

    eth_tx_pkg::tx_cfg_t      tx_cfg;
    eth_tx_pkg::tx_event_t    tx_events;
    eth_tx_pkg::stream_beat_t ins_beat;
    logic                     ins_valid;
    logic                     ins_ready;

    eth_tx_csr csr_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg_cmd   (cfg_cmd),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .events    (tx_events),
        .cfg       (tx_cfg)
    );

    eth_fcs_insert fcs_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg     (tx_cfg),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .o_beat  (ins_beat),
        .o_valid (ins_valid),
        .o_ready (ins_ready),
        .events  (tx_events),
        .busy    (busy)
    );

    // output stage toward the PHY side
    axis_skid_buffer skid_inst (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (ins_beat),
        .s_valid (ins_valid),
        .s_ready (ins_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// ==== testbench/eth_tx_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FCS, padding and register model
// frame counts hold only for reads while idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_tx_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    input  logic                     s_ready,
    input  eth_tx_pkg::stream_beat_t m_beat,
    input  logic                     m_valid,
    input  logic                     m_ready,
    input  eth_tx_pkg::cfg_cmd_t     cfg_cmd,
    input  logic                     cfg_req,
    input  logic                     cfg_ack,
    input  logic [15:0]              cfg_rdata,
    input  logic                     busy,
    output int                       data_errors,
    output int                       reg_errors,
    output int                       proto_errors,
    output int                       beats_checked,
    output int                       pending
);

    eth_tx_pkg::stream_beat_t exp_q[$];
    string                    tag_q[$];

    logic        in_frame, frame_pad, model_pad;
    logic        rst_prev, req_prev, ack_prev;
    logic [7:0]  model_min, frame_min;
    logic [15:0] good_count, bad_count;
    logic [31:0] crc;
    int          frame_len;
    string       frame_tag;

    // normal MSB-first CRC-32, data bits fed in wire order
    function automatic logic [31:0] crc_shift_byte(input logic [31:0] state, input logic [7:0] b);
        logic [31:0] s;
        logic        fb;
        s = state;
        for (int i = 0; i < 8; i++) begin
            fb = s[31] ^ b[i];
            s = {s[30:0], 1'b0};
            if (fb) begin
                s = s ^ 32'h04C1_1DB7;
            end
        end
        return s;
    endfunction

    // bit order reversed for the wire, then inverted
    function automatic logic [31:0] fcs_value(input logic [31:0] state);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = state[31 - i];
        end
        return ~r;
    endfunction

    task automatic expect_byte(input logic [7:0] data, input logic last, input logic user);
        eth_tx_pkg::stream_beat_t b;
        b.data = data;
        b.last = last;
        b.user = user;
        exp_q.push_back(b);
        tag_q.push_back(frame_tag);
    endtask

    always @(posedge clk) begin
        eth_tx_pkg::stream_beat_t got;
        eth_tx_pkg::stream_beat_t want;
        logic [31:0]              fcs;
        logic [15:0]              exp_rdata;
        int                       target;
        string                    name;

        if (rst) begin
            exp_q.delete();
            tag_q.delete();
            in_frame = 1'b0;
            model_pad = 1'b0;
            model_min = eth_tx_pkg::DEFAULT_MIN_FRAME_LEN;
            good_count = '0;
            bad_count = '0;
            req_prev = 1'b0;
            ack_prev = 1'b0;
        end else begin
            if (rst_prev && (m_valid || s_ready || cfg_ack || busy)) begin
                proto_errors++;
                $display("after reset m_valid %b s_ready %b cfg_ack %b busy %b, all should be low",
                         m_valid, s_ready, cfg_ack, busy);
            end

            // input side builds the expected output
            if (s_valid && s_ready) begin
                if (!in_frame) begin
                    in_frame = 1'b1;
                    frame_pad = model_pad;
                    frame_min = model_min;
                    frame_len = 0;
                    crc = 32'hFFFF_FFFF;
                    frame_tag = frame_pad ? $sformatf("pad_min%0d", frame_min) : "fcs_nopad";
                end
                frame_len++;
                crc = crc_shift_byte(crc, s_beat.data);
                if (s_beat.last && s_beat.user) begin
                    frame_tag = "bad_frame";
                    expect_byte(s_beat.data, 1'b1, 1'b1);
                    bad_count++;
                    in_frame = 1'b0;
                end else begin
                    expect_byte(s_beat.data, 1'b0, 1'b0);
                end
                if (s_beat.last && !s_beat.user) begin
                    target = (frame_min > 8'd4) ? int'(frame_min) - 4 : 0;
                    while (frame_pad && frame_len < target) begin
                        expect_byte(8'h00, 1'b0, 1'b0);
                        crc = crc_shift_byte(crc, 8'h00);
                        frame_len++;
                    end
                    fcs = fcs_value(crc);
                    for (int k = 0; k < 4; k++) begin
                        expect_byte(fcs[8*k +: 8], k == 3, 1'b0);
                    end
                    good_count++;
                    in_frame = 1'b0;
                end
            end

            if (m_valid && m_ready) begin
                got = m_beat;
                if (exp_q.size() == 0) begin
                    proto_errors++;
                    $display("output byte %02h arrived while no byte was expected", got.data);
                end else begin
                    want = exp_q.pop_front();
                    name = tag_q.pop_front();
                    beats_checked++;
                    if (got !== want) begin
                        data_errors++;
                        $display(
                            "ERROR %s: expected %02h last %b user %b, actual %02h last %b user %b",
                            name, want.data, want.last, want.user,
                            got.data, got.last, got.user);
                    end
                end
            end

            // ack follows the request by one cycle
            if (cfg_ack !== req_prev) begin
                proto_errors++;
                $display("cfg_ack is %b but cfg_req one cycle earlier was %b", cfg_ack, req_prev);
            end
            if (cfg_req && !cfg_ack && cfg_cmd.write) begin
                if (cfg_cmd.addr == eth_tx_pkg::CSR_ADDR_CTRL) begin
                    model_pad = cfg_cmd.wdata[0];
                end
                if (cfg_cmd.addr == eth_tx_pkg::CSR_ADDR_MINLEN) begin
                    model_min = cfg_cmd.wdata[7:0];
                end
            end
            if (cfg_ack && !ack_prev && !cfg_cmd.write) begin
                case (cfg_cmd.addr)
                    eth_tx_pkg::CSR_ADDR_CTRL: begin
                        exp_rdata = {15'h0, model_pad};
                        name = "csr_ctrl";
                    end
                    eth_tx_pkg::CSR_ADDR_MINLEN: begin
                        exp_rdata = {8'h0, model_min};
                        name = "csr_minlen";
                    end
                    eth_tx_pkg::CSR_ADDR_FRAMES: begin
                        exp_rdata = good_count;
                        name = "csr_frames";
                    end
                    default: begin
                        exp_rdata = bad_count;
                        name = "csr_errors";
                    end
                endcase
                if (cfg_rdata !== exp_rdata) begin
                    reg_errors++;
                    $display("ERROR %s: expected %04h, actual %04h", name, exp_rdata, cfg_rdata);
                end
            end
            req_prev = cfg_req;
            ack_prev = cfg_ack;
        end
        rst_prev = rst;
        pending <= exp_q.size();
    end

endmodule

// ==== testbench/eth_tx_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake rules at the top level ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module eth_tx_sva (
    input logic                     clk,
    input logic                     rst,
    input eth_tx_pkg::stream_beat_t m_beat,
    input logic                     m_valid,
    input logic                     m_ready,
    input logic                     cfg_req,
    input logic                     cfg_ack
);

    // stalled beat must hold
    out_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
        else $error("output beat changed while stalled");

    ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(cfg_ack) |-> cfg_req)
        else $error("cfg_ack rose without a request");

    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(cfg_req) |=> !cfg_ack)
        else $error("cfg_ack still high a cycle after the request fell");

endmodule

bind eth_tx_top eth_tx_sva sva_inst (
    .clk     (clk),
    .rst     (rst),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .cfg_req (cfg_req),
    .cfg_ack (cfg_ack)
);

// ==== testbench/tb_eth_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random frames in three config groups, fixed seed
// config traffic only while the framer is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_eth_tx;

    localparam logic [31:0] SEED = 32'hf8f5_9cdf;
    // frames x longest frame x stall factor, plus config traffic
    localparam int MAX_CYCLES = 100 * 90 * 3 + 2000;

    logic                     clk;
    logic                     rst;
    eth_tx_pkg::stream_beat_t s_beat;
    logic                     s_valid;
    logic                     s_ready;
    eth_tx_pkg::stream_beat_t m_beat;
    logic                     m_valid;
    logic                     m_ready;
    eth_tx_pkg::cfg_cmd_t     cfg_cmd;
    logic                     cfg_req;
    logic                     cfg_ack;
    logic [15:0]              cfg_rdata;
    logic                     busy;

    integer seed;
    integer ready_seed;
    int     cycles;
    int     data_errors;
    int     reg_errors;
    int     proto_errors;
    int     beats_checked;
    int     pending;

    eth_tx_top eth_tx_top_inst (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .m_beat    (m_beat),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .cfg_cmd   (cfg_cmd),
        .cfg_req   (cfg_req),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .busy      (busy)
    );

    eth_tx_checker check_inst (
        .clk           (clk),
        .rst           (rst),
        .s_beat        (s_beat),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .cfg_cmd       (cfg_cmd),
        .cfg_req       (cfg_req),
        .cfg_ack       (cfg_ack),
        .cfg_rdata     (cfg_rdata),
        .busy          (busy),
        .data_errors   (data_errors),
        .reg_errors    (reg_errors),
        .proto_errors  (proto_errors),
        .beats_checked (beats_checked),
        .pending       (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // output ready high about 70 percent of cycles
    initial begin
        ready_seed = SEED ^ 32'h0000_5a5a;
        m_ready = 1'b0;
        forever begin
            @(posedge clk);
            m_ready <= !rst && (($unsigned($random(ready_seed)) % 10) < 7);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles, %0d output bytes still expected",
                 cycles, pending);
        $display("CHECKS FAILED");
        $finish;
    end

    // four-phase access, the checker compares the read data
    task automatic cfg_access(input logic wr, input logic [1:0] addr, input logic [15:0] wdata);
        cfg_cmd.write <= wr;
        cfg_cmd.addr <= addr;
        cfg_cmd.wdata <= wdata;
        cfg_req <= 1'b1;
        @(posedge clk);
        while (!cfg_ack) @(posedge clk);
        cfg_req <= 1'b0;
        @(posedge clk);
        while (cfg_ack) @(posedge clk);
    endtask

    task automatic send_frame(input int len, input logic bad);
        int i;
        for (i = 0; i < len; i++) begin
            s_valid <= 1'b1;
            s_beat.data <= 8'($random(seed));
            s_beat.last <= (i == len - 1);
            s_beat.user <= bad && (i == len - 1);
            @(posedge clk);
            while (!s_ready) @(posedge clk);
        end
        s_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (busy) @(posedge clk);
    endtask

    task automatic run_group(input int frames, input logic pad, input logic [7:0] min_len);
        int   i;
        int   len;
        logic bad;
        cfg_access(1'b1, eth_tx_pkg::CSR_ADDR_CTRL, {15'h0, pad});
        cfg_access(1'b1, eth_tx_pkg::CSR_ADDR_MINLEN, {8'h0, min_len});
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_CTRL, 16'h0);
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_MINLEN, 16'h0);
        for (i = 0; i < frames; i++) begin
            len = int'($unsigned($random(seed)) % 80) + 1;
            // about one frame in six marked bad
            bad = (($unsigned($random(seed)) % 6) == 0);
            send_frame(len, bad);
            repeat ($unsigned($random(seed)) % 3) @(posedge clk);
        end
        wait_idle();
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_FRAMES, 16'h0);
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_ERRORS, 16'h0);
    endtask

    initial begin
        seed = SEED;
        rst = 1'b1;
        s_valid = 1'b0;
        s_beat = '0;
        cfg_req = 1'b0;
        cfg_cmd = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // reset values before any write
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_CTRL, 16'h0);
        cfg_access(1'b0, eth_tx_pkg::CSR_ADDR_MINLEN, 16'h0);
        run_group(40, 1'b0, 8'd64);
        run_group(40, 1'b1, 8'd64);
        run_group(20, 1'b1, 8'd32);
        while (pending != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("%0d beats checked, %0d data errors, %0d register errors, %0d protocol errors",
                 beats_checked, data_errors, reg_errors, proto_errors);
        if (data_errors + reg_errors + proto_errors == 0 && beats_checked > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/eth_tx_pkg.sv
src/eth_crc32_byte.sv
src/eth_fcs_insert.sv
src/axis_skid_buffer.sv
src/eth_tx_csr.sv
src/eth_tx_top.sv
testbench/eth_tx_checker.sv
testbench/eth_tx_sva.sv
testbench/tb_eth_tx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the framer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_eth_tx
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out="$(./obj_dir/Vtb_eth_tx)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
